// File: design/cpuTypesPkg.sv
// Pipeline types and encodings
`default_nettype none

package cpuTypesPkg;

        localparam int WORD_W    = 32;
        localparam int REG_SEL_W = 5;
        localparam int IMM_W     = 16;
        localparam int ADDR_W    = 26;

        typedef enum logic [3:0] {
                ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
                ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
        } aluOp;

        typedef enum logic [5:0] {
                RTYPE = 6'h00, J = 6'h02, JAL = 6'h03, BEQ = 6'h04, BNE = 6'h05,
                ADDIU = 6'h09, SLTI = 6'h0a, SLTIU = 6'h0b, ANDI = 6'h0c, ORI = 6'h0d,
                XORI = 6'h0e, LUI = 6'h0f, LW = 6'h23, SW = 6'h2b, HALT = 6'h3f
        } opcodeT;

        typedef enum logic [5:0] {
                SLL = 6'h00, SRL = 6'h02, JR = 6'h08, ADDU = 6'h21, SUBU = 6'h23,
                AND = 6'h24, OR = 6'h25, XOR = 6'h26, NOR = 6'h27, SLT = 6'h2a,
                SLTU = 6'h2b
        } functT;

        // JMP_LINK also writes NPC to r31
        typedef enum logic [1:0] {JMP_NONE, JMP_TARGET, JMP_REG, JMP_LINK} jumpSelT;

        typedef struct packed {
                opcodeT opcode;
                logic [REG_SEL_W-1:0] rs;
                logic [REG_SEL_W-1:0] rt;
                logic [REG_SEL_W-1:0] rd;
                logic [REG_SEL_W-1:0] shamt;
                functT funct;
        } rFormat;

        typedef struct packed {
                opcodeT opcode;
                logic [REG_SEL_W-1:0] rs;
                logic [REG_SEL_W-1:0] rt;
                logic [IMM_W-1:0] imm16;
        } iFormat;

        typedef struct packed {
                opcodeT opcode;
                logic [ADDR_W-1:0] addr26;
        } jFormat;

        // Same word, three field layouts
        typedef union packed {
                rFormat r;
                iFormat i;
                jFormat j;
        } instrWord;

        typedef struct packed {
                instrWord instr;
                logic [WORD_W-1:0] npc;
        } ifidRegs;

        typedef struct packed {
                aluOp aluCtr;
                logic aluSrc;
                logic beq;
                logic bne;
                jumpSelT jumpSel;
                logic [ADDR_W-1:0] jumpAddr;
        } exeCtrl;

        typedef struct packed {
                logic dRen;
                logic dWen;
        } memCtrl;

        typedef struct packed {
                logic regWr;
                logic memToReg;
                logic halt;
        } wbCtrl;

        typedef struct packed {
                exeCtrl exe;
                memCtrl mem;
                wbCtrl wb;
                logic [WORD_W-1:0] npc;
                logic [REG_SEL_W-1:0] rw;
                logic [WORD_W-1:0] portA;
                logic [WORD_W-1:0] portB;
                logic [WORD_W-1:0] immExt;
                logic [REG_SEL_W-1:0] shamt;
        } idexRegs;

        // Handed on to the memory stage
        typedef struct packed {
                logic [WORD_W-1:0] aluResult;
                logic [WORD_W-1:0] storeData;
                logic branchTaken;
                logic [WORD_W-1:0] target;
                memCtrl mem;
                wbCtrl wb;
                logic [REG_SEL_W-1:0] rw;
        } exeResult;

endpackage

`default_nettype wire

// File: design/ifidLatch.sv
// IF/ID pipeline register
`timescale 1ns/10ps
`default_nettype none

module ifidLatch (
        input  logic CLK,
        input  logic nRST,
        input  logic ihit,
        input  logic stall,
        input  logic flush,
        input  logic [cpuTypesPkg::WORD_W-1:0] instrIn,
        input  logic [cpuTypesPkg::WORD_W-1:0] npcIn,
        output cpuTypesPkg::ifidRegs ifid
);

        // Only ihit edges move the pipe
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        ifid <= '0;
                end else if (ihit) begin
                        if (flush) begin
                                // Zero word is SLL r0, a no-op
                                ifid <= '0;
                        end else if (!stall) begin
                                ifid <= {instrIn, npcIn};
                        end
                end
        end

endmodule

`default_nettype wire

// File: design/controlDecoder.sv
// Instruction decoder
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
        input  cpuTypesPkg::instrWord instr,
        input  logic [cpuTypesPkg::WORD_W-1:0] npc,
        output logic [cpuTypesPkg::REG_SEL_W-1:0] rs,
        output logic [cpuTypesPkg::REG_SEL_W-1:0] rt,
        output cpuTypesPkg::idexRegs decoded
);

        import cpuTypesPkg::*;

        logic [WORD_W-1:0] signExt;
        logic [WORD_W-1:0] zeroExt;

        assign signExt = {{(WORD_W-IMM_W){instr.i.imm16[IMM_W-1]}}, instr.i.imm16};
        assign zeroExt = {{(WORD_W-IMM_W){1'b0}}, instr.i.imm16};

        // LUI reads r0 so operand A is zero
        assign rs = (instr.i.opcode == LUI) ? '0 : instr.i.rs;
        assign rt = instr.i.rt;

        always_comb begin
                decoded = '0;
                decoded.exe.aluCtr = ALU_ADD;
                decoded.exe.jumpAddr = instr.j.addr26;
                decoded.npc = npc;
                decoded.shamt = instr.r.shamt;
                decoded.immExt = signExt;
                decoded.rw = instr.i.rt;

                case (instr.r.opcode)
                        RTYPE: begin
                                decoded.rw = instr.r.rd;
                                decoded.wb.regWr = 1'b1;
                                case (instr.r.funct)
                                        SLL:  decoded.exe.aluCtr = ALU_SLL;
                                        SRL:  decoded.exe.aluCtr = ALU_SRL;
                                        ADDU: decoded.exe.aluCtr = ALU_ADD;
                                        SUBU: decoded.exe.aluCtr = ALU_SUB;
                                        AND:  decoded.exe.aluCtr = ALU_AND;
                                        OR:   decoded.exe.aluCtr = ALU_OR;
                                        XOR:  decoded.exe.aluCtr = ALU_XOR;
                                        NOR:  decoded.exe.aluCtr = ALU_NOR;
                                        SLT:  decoded.exe.aluCtr = ALU_SLT;
                                        SLTU: decoded.exe.aluCtr = ALU_SLTU;
                                        JR: begin
                                                decoded.exe.jumpSel = JMP_REG;
                                                decoded.wb.regWr = 1'b0;
                                        end
                                        default: decoded.wb.regWr = 1'b0;
                                endcase
                        end
                        J: decoded.exe.jumpSel = JMP_TARGET;
                        JAL: begin
                                decoded.exe.jumpSel = JMP_LINK;
                                decoded.rw = 5'd31;
                                decoded.wb.regWr = 1'b1;
                        end
                        BEQ: decoded.exe.beq = 1'b1;
                        BNE: decoded.exe.bne = 1'b1;
                        ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: begin
                                decoded.exe.aluSrc = 1'b1;
                                decoded.wb.regWr = 1'b1;
                                case (instr.i.opcode)
                                        SLTI:  decoded.exe.aluCtr = ALU_SLT;
                                        SLTIU: decoded.exe.aluCtr = ALU_SLTU;
                                        ANDI:  decoded.exe.aluCtr = ALU_AND;
                                        ORI:   decoded.exe.aluCtr = ALU_OR;
                                        XORI:  decoded.exe.aluCtr = ALU_XOR;
                                        LUI:   decoded.exe.aluCtr = ALU_OR;
                                        default: decoded.exe.aluCtr = ALU_ADD;
                                endcase
                                if (instr.i.opcode inside {ANDI, ORI, XORI}) begin
                                        decoded.immExt = zeroExt;
                                end
                                if (instr.i.opcode == LUI) begin
                                        decoded.immExt = {instr.i.imm16, {(WORD_W-IMM_W){1'b0}}};
                                end
                        end
                        LW: begin
                                decoded.exe.aluSrc = 1'b1;
                                decoded.mem.dRen = 1'b1;
                                decoded.wb.memToReg = 1'b1;
                                decoded.wb.regWr = 1'b1;
                        end
                        SW: begin
                                decoded.exe.aluSrc = 1'b1;
                                decoded.mem.dWen = 1'b1;
                        end
                        HALT: decoded.wb.halt = 1'b1;
                        default: ;
                endcase

                // Writes to r0 dropped, so the zero word is a clean no-op
                if (decoded.rw == '0) begin
                        decoded.wb.regWr = 1'b0;
                end
        end

endmodule

`default_nettype wire

// File: design/registerFile.sv
// Register file, 2 read and 1 write port
`timescale 1ns/10ps
`default_nettype none

module registerFile (
        input  logic CLK,
        input  logic nRST,
        input  logic [cpuTypesPkg::REG_SEL_W-1:0] rs,
        input  logic [cpuTypesPkg::REG_SEL_W-1:0] rt,
        input  logic wbEn,
        input  logic [cpuTypesPkg::REG_SEL_W-1:0] wbSel,
        input  logic [cpuTypesPkg::WORD_W-1:0] wbData,
        output logic [cpuTypesPkg::WORD_W-1:0] portA,
        output logic [cpuTypesPkg::WORD_W-1:0] portB
);

        import cpuTypesPkg::*;

        logic [WORD_W-1:0] regs [2**REG_SEL_W];
        logic writeHit;

        // r0 is never written
        assign writeHit = wbEn && (wbSel != '0);

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        regs <= '{default: '0};
                end else if (writeHit) begin
                        regs[wbSel] <= wbData;
                end
        end

        // Same-cycle write passes straight through
        assign portA = (rs == '0) ? '0 :
                       (writeHit && wbSel == rs) ? wbData : regs[rs];
        assign portB = (rt == '0) ? '0 :
                       (writeHit && wbSel == rt) ? wbData : regs[rt];

        r0StaysZero: assert property (@(posedge CLK) disable iff (!nRST)
                (wbEn && wbSel == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// File: design/idexLatch.sv
// ID/EX pipeline register
`timescale 1ns/10ps
`default_nettype none

module idexLatch (
        input  logic CLK,
        input  logic nRST,
        input  logic ihit,
        input  logic stall,
        input  logic flush,
        input  cpuTypesPkg::idexRegs decoded,
        output cpuTypesPkg::idexRegs idex
);

        import cpuTypesPkg::*;

        // Bubble entry, ALU left on add
        localparam idexRegs clearedEntry = '{
                exe: '{aluCtr: ALU_ADD, aluSrc: 1'b0, beq: 1'b0, bne: 1'b0,
                       jumpSel: JMP_NONE, jumpAddr: '0},
                mem: '{dRen: 1'b0, dWen: 1'b0},
                wb: '{regWr: 1'b0, memToReg: 1'b0, halt: 1'b0},
                npc: '0,
                rw: '0,
                portA: '0,
                portB: '0,
                immExt: '0,
                shamt: '0
        };

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        idex <= clearedEntry;
                end else if (ihit) begin
                        // Flush wins over stall
                        if (flush) begin
                                idex <= clearedEntry;
                        end else if (!stall) begin
                                idex <= decoded;
                        end
                end
        end

        memOneHot: assert property (@(posedge CLK) disable iff (!nRST)
                !(idex.mem.dRen && idex.mem.dWen));

        flushBubble: assert property (@(posedge CLK) disable iff (!nRST)
                (flush && ihit) |=> (!idex.wb.regWr && !idex.wb.halt));

endmodule

`default_nettype wire

// File: design/executeUnit.sv
// Execute stage ALU and branch logic
`timescale 1ns/10ps
`default_nettype none

module executeUnit (
        input  cpuTypesPkg::idexRegs idex,
        output cpuTypesPkg::exeResult result
);

        import cpuTypesPkg::*;

        logic [WORD_W-1:0] opA;
        logic [WORD_W-1:0] opB;
        logic [WORD_W-1:0] aluOut;
        logic [WORD_W-1:0] branchTarget;
        logic [WORD_W-1:0] jumpTarget;
        logic equal;

        assign opA = idex.portA;
        assign opB = idex.exe.aluSrc ? idex.immExt : idex.portB;

        always_comb begin
                case (idex.exe.aluCtr)
                        ALU_SLL:  aluOut = opB << idex.shamt;
                        ALU_SRL:  aluOut = opB >> idex.shamt;
                        ALU_ADD:  aluOut = opA + opB;
                        ALU_SUB:  aluOut = opA - opB;
                        ALU_AND:  aluOut = opA & opB;
                        ALU_OR:   aluOut = opA | opB;
                        ALU_XOR:  aluOut = opA ^ opB;
                        ALU_NOR:  aluOut = ~(opA | opB);
                        ALU_SLT:  aluOut = {{(WORD_W-1){1'b0}}, $signed(opA) < $signed(opB)};
                        ALU_SLTU: aluOut = {{(WORD_W-1){1'b0}}, opA < opB};
                        default:  aluOut = '0;
                endcase
        end

        // Compare uses register values even for immediates
        assign equal = (idex.portA == idex.portB);

        assign branchTarget = idex.npc + (idex.immExt << 2);
        assign jumpTarget = {idex.npc[WORD_W-1:WORD_W-4], idex.exe.jumpAddr, 2'b00};

        always_comb begin
                result.branchTaken = (idex.exe.beq && equal) ||
                                     (idex.exe.bne && !equal) ||
                                     (idex.exe.jumpSel != JMP_NONE);

                case (idex.exe.jumpSel)
                        JMP_TARGET, JMP_LINK: result.target = jumpTarget;
                        JMP_REG:              result.target = idex.portA;
                        default:              result.target = branchTarget;
                endcase

                // Link value goes out on the ALU path
                result.aluResult = (idex.exe.jumpSel == JMP_LINK) ? idex.npc : aluOut;
                result.storeData = idex.portB;
                result.mem = idex.mem;
                result.wb = idex.wb;
                result.rw = idex.rw;

                // Decoder never sets both
                assert (!(idex.exe.beq && idex.exe.bne));
        end

endmodule

`default_nettype wire

// File: design/cpuDecodeExecute.sv
// Decode to execute pipeline slice
`timescale 1ns/10ps
`default_nettype none

module cpuDecodeExecute (
        input  logic CLK,
        input  logic nRST,
        input  logic [cpuTypesPkg::WORD_W-1:0] instr,
        input  logic [cpuTypesPkg::WORD_W-1:0] npc,
        input  logic ihit,
        input  logic stall,
        input  logic flush,
        input  logic wbEn,
        input  logic [cpuTypesPkg::REG_SEL_W-1:0] wbSel,
        input  logic [cpuTypesPkg::WORD_W-1:0] wbData,
        output cpuTypesPkg::exeResult result
);

        import cpuTypesPkg::*;

        ifidRegs ifid;
        idexRegs decoded;
        idexRegs idexIn;
        idexRegs idex;
        logic [REG_SEL_W-1:0] rs;
        logic [REG_SEL_W-1:0] rt;
        logic [WORD_W-1:0] portA;
        logic [WORD_W-1:0] portB;

        ifidLatch ifid0 (
                .CLK(CLK), .nRST(nRST), .ihit(ihit), .stall(stall), .flush(flush),
                .instrIn(instr), .npcIn(npc), .ifid(ifid)
        );

        controlDecoder decoder0 (
                .instr(ifid.instr), .npc(ifid.npc), .rs(rs), .rt(rt), .decoded(decoded)
        );

        registerFile regFile0 (
                .CLK(CLK), .nRST(nRST), .rs(rs), .rt(rt),
                .wbEn(wbEn), .wbSel(wbSel), .wbData(wbData),
                .portA(portA), .portB(portB)
        );

        // Register reads join the decoded fields
        assign idexIn = '{exe: decoded.exe, mem: decoded.mem, wb: decoded.wb,
                          npc: decoded.npc, rw: decoded.rw, portA: portA, portB: portB,
                          immExt: decoded.immExt, shamt: decoded.shamt};

        idexLatch idex0 (
                .CLK(CLK), .nRST(nRST), .ihit(ihit), .stall(stall), .flush(flush),
                .decoded(idexIn), .idex(idex)
        );

        executeUnit exe0 (
                .idex(idex), .result(result)
        );

endmodule

`default_nettype wire

// File: sim/executeChecker.sv
// Execute result checker
`timescale 1ns/10ps
`default_nettype none

module executeChecker (
        input  logic CLK,
        input  logic nRST,
        input  cpuTypesPkg::exeResult result,
        input  cpuTypesPkg::exeResult expected,
        input  cpuTypesPkg::exeResult mask,
        output int errors,
        output int checks
);

        import cpuTypesPkg::*;

        // Only bits set in the mask take part
        task automatic compareField(input string name, input logic [31:0] act,
                        input logic [31:0] exp, input logic [31:0] msk);
                if (((act ^ exp) & msk) !== 32'h0) begin
                        $display("Mismatch result.%s at %0t: expected %h, actual %h",
                                 name, $time, exp & msk, act);
                        errors++;
                end
        endtask

        initial begin
                errors = 0;
                checks = 0;
        end

        // Falling edge, well clear of the driving edge
        always @(negedge CLK) begin
                if (nRST && mask != '0) begin
                        checks++;
                        compareField("aluResult", result.aluResult, expected.aluResult,
                                     mask.aluResult);
                        compareField("storeData", result.storeData, expected.storeData,
                                     mask.storeData);
                        compareField("branchTaken", 32'(result.branchTaken),
                                     32'(expected.branchTaken), 32'(mask.branchTaken));
                        compareField("target", result.target, expected.target, mask.target);
                        compareField("mem", 32'(result.mem), 32'(expected.mem), 32'(mask.mem));
                        compareField("wb", 32'(result.wb), 32'(expected.wb), 32'(mask.wb));
                        compareField("rw", 32'(result.rw), 32'(expected.rw), 32'(mask.rw));
                end
        end

endmodule

`default_nettype wire

// File: sim/cpuDecodeExecuteTb.sv
// Decode to execute slice testbench
`timescale 1ns/10ps
`default_nettype none

module cpuDecodeExecuteTb;

        import cpuTypesPkg::*;

        localparam int MAX_ROWS = 96;
        localparam int RESET_CYCLES = 10;

        // Memory and writeback bits as {dRen, dWen, regWr, memToReg, halt}
        localparam logic [4:0] CTL_NONE = 5'b00000;
        localparam logic [4:0] CTL_WR = 5'b00100;
        localparam logic [4:0] CTL_LD = 5'b10110;
        localparam logic [4:0] CTL_ST = 5'b01000;
        localparam logic [4:0] CTL_HALT = 5'b00001;

        typedef struct packed {
                logic [WORD_W-1:0] instr;
                logic [WORD_W-1:0] npc;
                logic ihit;
                logic stall;
                logic flush;
                logic wbEn;
                logic [REG_SEL_W-1:0] wbSel;
                logic [WORD_W-1:0] wbData;
        } stimRow;

        logic CLK;
        logic nRST;
        logic [WORD_W-1:0] instr;
        logic [WORD_W-1:0] npc;
        logic ihit;
        logic stall;
        logic flush;
        logic wbEn;
        logic [REG_SEL_W-1:0] wbSel;
        logic [WORD_W-1:0] wbData;
        exeResult result;
        exeResult expNow;
        exeResult maskNow;
        int errors;
        int checks;

        // Row i holds the inputs and the result expected while they are applied
        stimRow stim [MAX_ROWS];
        exeResult expV [MAX_ROWS];
        exeResult maskV [MAX_ROWS];
        logic [WORD_W-1:0] rf [32];
        logic [WORD_W-1:0] pc;
        int nRows;
        int seed;
        int row;

        cpuDecodeExecute dut0 (
                .CLK(CLK), .nRST(nRST), .instr(instr), .npc(npc), .ihit(ihit),
                .stall(stall), .flush(flush), .wbEn(wbEn), .wbSel(wbSel),
                .wbData(wbData), .result(result)
        );

        executeChecker check0 (
                .CLK(CLK), .nRST(nRST), .result(result), .expected(expNow),
                .mask(maskNow), .errors(errors), .checks(checks)
        );

        always #2 CLK = ~CLK;

        function automatic logic [31:0] rIns(functT f, int rs, int rt, int rd, int sh);
                return {RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
        endfunction

        function automatic logic [31:0] iIns(opcodeT op, int rs, int rt, int imm);
                return {op, 5'(rs), 5'(rt), 16'(imm)};
        endfunction

        function automatic logic [31:0] jIns(opcodeT op, int addr);
                return {op, 26'(addr)};
        endfunction

        function automatic exeResult mk(logic [31:0] alu, logic [31:0] store, logic taken,
                        logic [31:0] tgt, logic [4:0] ctl, int rw);
                exeResult e;
                e.aluResult = alu;
                e.storeData = store;
                e.branchTaken = taken;
                e.target = tgt;
                {e.mem, e.wb} = ctl;
                e.rw = 5'(rw);
                return e;
        endfunction

        // Control bits and branchTaken are always compared
        function automatic exeResult msk(bit alu, bit store, bit tgt, bit rwOn);
                exeResult m;
                m = '1;
                if (!alu) m.aluResult = '0;
                if (!store) m.storeData = '0;
                if (!tgt) m.target = '0;
                if (!rwOn) m.rw = '0;
                return m;
        endfunction

        task automatic addRow(input logic [31:0] w, input logic ih, input logic st,
                        input logic fl, input logic we, input int ws, input logic [31:0] wd);
                stim[nRows] = '{w, pc, ih, st, fl, we, 5'(ws), wd};
                nRows++;
                pc += 4;
        endtask

        task automatic idleRow();
                addRow(32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 0, 32'h0);
        endtask

        task automatic expectAt(input int idx, input exeResult e, input exeResult m);
                expV[idx] = e;
                maskV[idx] = m;
        endtask

        // Result shows up two ihit edges after the row
        task automatic issue(input logic [31:0] w, input exeResult e, input exeResult m);
                expectAt(nRows + 2, e, m);
                idleRow();
                stim[nRows-1].instr = w;
        endtask

        task automatic preload(input int r, input logic [31:0] v);
                rf[r] = v;
                addRow(32'h0, 1'b1, 1'b0, 1'b0, 1'b1, r, v);
        endtask

        // The middle row is held back by stall or by ihit low
        task automatic holdCase(input logic ih, input logic st);
                int k;
                exeResult mAlu;
                k = nRows;
                mAlu = msk(1, 0, 0, 1);
                issue(rIns(XOR, 1, 2, 14, 0),
                      mk(rf[1] ^ rf[2], 32'h0, 1'b0, 32'h0, CTL_WR, 14), mAlu);
                addRow(rIns(ADDU, 2, 4, 15, 0), 1'b1, 1'b0, 1'b0, 1'b0, 0, 32'h0);
                addRow(rIns(SUBU, 4, 1, 16, 0), ih, st, 1'b0, 1'b0, 0, 32'h0);
                addRow(rIns(SUBU, 4, 1, 16, 0), 1'b1, 1'b0, 1'b0, 1'b0, 0, 32'h0);
                expectAt(k + 3, mk(rf[1] ^ rf[2], 32'h0, 1'b0, 32'h0, CTL_WR, 14), mAlu);
                expectAt(k + 4, mk(rf[2] + rf[4], 32'h0, 1'b0, 32'h0, CTL_WR, 15), mAlu);
                expectAt(k + 5, mk(rf[4] - rf[1], 32'h0, 1'b0, 32'h0, CTL_WR, 16), mAlu);
        endtask

        task automatic flushCase();
                int k;
                exeResult mAlu;
                k = nRows;
                mAlu = msk(1, 0, 0, 1);
                issue(rIns(OR, 1, 2, 19, 0),
                      mk(rf[1] | rf[2], 32'h0, 1'b0, 32'h0, CTL_WR, 19), mAlu);
                addRow(rIns(ADDU, 1, 1, 20, 0), 1'b1, 1'b0, 1'b0, 1'b0, 0, 32'h0);
                addRow(rIns(ADDU, 2, 2, 21, 0), 1'b1, 1'b0, 1'b1, 1'b0, 0, 32'h0);
                issue(rIns(SUBU, 2, 1, 22, 0),
                      mk(rf[2] - rf[1], 32'h0, 1'b0, 32'h0, CTL_WR, 22), mAlu);
                // ID/EX bubble first, then the cleared IF/ID word decoded as SLL r0
                expectAt(k + 3, '0, '1);
                expectAt(k + 4, '0, '1);
        endtask

        task automatic buildTable();
                int i;
                exeResult mAlu;
                exeResult mBr;
                mAlu = msk(1, 0, 0, 1);
                mBr = msk(0, 0, 1, 1);
                nRows = 0;
                seed = 82568;
                pc = 32'h1040_0000;
                for (i = 0; i < MAX_ROWS; i++) begin
                        expV[i] = '0;
                        maskV[i] = '0;
                end
                for (i = 0; i < 32; i++) begin
                        rf[i] = '0;
                end

                expectAt(0, '0, '1);
                preload(1, $random(seed));
                preload(2, $random(seed));
                preload(4, $random(seed));
                preload(5, $random(seed));
                preload(3, rf[1]);

                // R-type arithmetic
                issue(rIns(ADDU, 1, 2, 7, 0), mk(rf[1] + rf[2], 0, 1'b0, 0, CTL_WR, 7), mAlu);
                issue(rIns(SUBU, 1, 2, 8, 0), mk(rf[1] - rf[2], 0, 1'b0, 0, CTL_WR, 8), mAlu);
                issue(rIns(AND, 1, 2, 9, 0), mk(rf[1] & rf[2], 0, 1'b0, 0, CTL_WR, 9), mAlu);
                issue(rIns(OR, 1, 2, 10, 0), mk(rf[1] | rf[2], 0, 1'b0, 0, CTL_WR, 10), mAlu);
                issue(rIns(XOR, 1, 2, 11, 0), mk(rf[1] ^ rf[2], 0, 1'b0, 0, CTL_WR, 11), mAlu);
                issue(rIns(NOR, 1, 2, 12, 0),
                      mk(~(rf[1] | rf[2]), 0, 1'b0, 0, CTL_WR, 12), mAlu);
                issue(rIns(SLT, 1, 2, 13, 0),
                      mk({31'b0, $signed(rf[1]) < $signed(rf[2])}, 0, 1'b0, 0, CTL_WR, 13),
                      mAlu);
                issue(rIns(SLTU, 1, 2, 14, 0),
                      mk({31'b0, rf[1] < rf[2]}, 0, 1'b0, 0, CTL_WR, 14), mAlu);
                issue(rIns(SLL, 0, 5, 15, 4), mk(rf[5] << 4, 0, 1'b0, 0, CTL_WR, 15), mAlu);
                issue(rIns(SRL, 0, 5, 16, 7), mk(rf[5] >> 7, 0, 1'b0, 0, CTL_WR, 16), mAlu);

                // r6 is written in the same cycle that ADDU reads it
                rf[6] = 32'h1357_9bdf;
                issue(rIns(ADDU, 1, 6, 17, 0), mk(rf[1] + rf[6], 0, 1'b0, 0, CTL_WR, 17), mAlu);
                addRow(32'h0, 1'b1, 1'b0, 1'b0, 1'b1, 6, rf[6]);

                // I-type
                issue(iIns(ADDIU, 1, 18, 'hfff0),
                      mk(rf[1] + 32'hffff_fff0, 0, 1'b0, 0, CTL_WR, 18), mAlu);
                issue(iIns(SLTI, 1, 19, 'h8000),
                      mk({31'b0, $signed(rf[1]) < $signed(32'hffff_8000)}, 0, 1'b0, 0,
                         CTL_WR, 19), mAlu);
                issue(iIns(ANDI, 1, 20, 'hf0f0),
                      mk(rf[1] & 32'h0000_f0f0, 0, 1'b0, 0, CTL_WR, 20), mAlu);
                issue(iIns(ORI, 2, 21, 'h8001),
                      mk(rf[2] | 32'h0000_8001, 0, 1'b0, 0, CTL_WR, 21), mAlu);
                issue(iIns(LUI, 0, 22, 'hbeef), mk(32'hbeef_0000, 0, 1'b0, 0, CTL_WR, 22), mAlu);
                issue(iIns(LW, 4, 23, 'h10), mk(rf[4] + 32'h10, 0, 1'b0, 0, CTL_LD, 23), mAlu);
                issue(iIns(SW, 4, 2, 'hfffc),
                      mk(rf[4] + 32'hffff_fffc, rf[2], 1'b0, 0, CTL_ST, 2), msk(1, 1, 0, 1));

                // Branches and jumps
                issue(iIns(BEQ, 1, 3, 'h5),
                      mk(0, 0, rf[1] == rf[3], pc + 32'h14, CTL_NONE, 3), mBr);
                issue(iIns(BEQ, 1, 2, 'hfffe),
                      mk(0, 0, rf[1] == rf[2], pc + 32'hffff_fff8, CTL_NONE, 2), mBr);
                issue(iIns(BNE, 1, 2, 'h3),
                      mk(0, 0, rf[1] != rf[2], pc + 32'hc, CTL_NONE, 2), mBr);
                issue(iIns(BNE, 1, 3, 'h10),
                      mk(0, 0, rf[1] != rf[3], pc + 32'h40, CTL_NONE, 3), mBr);
                issue(jIns(J, 'h0123456),
                      mk(0, 0, 1'b1, {pc[31:28], 26'h0123456, 2'b00}, CTL_NONE, 0),
                      msk(0, 0, 1, 0));
                issue(jIns(JAL, 'h40),
                      mk(pc, 0, 1'b1, {pc[31:28], 26'h40, 2'b00}, CTL_WR, 31), msk(1, 0, 1, 1));
                issue(rIns(JR, 4, 0, 0, 0), mk(0, 0, 1'b1, rf[4], CTL_NONE, 0), mBr);

                // Stall, ihit low and flush
                holdCase(1'b1, 1'b1);
                holdCase(1'b0, 1'b0);
                flushCase();

                // HALT then r0 written before and during a read
                issue(jIns(HALT, 0), mk(0, 0, 1'b0, 0, CTL_HALT, 0), msk(0, 0, 0, 0));
                addRow(32'h0, 1'b1, 1'b0, 1'b0, 1'b1, 0, 32'hffff_ffff);
                issue(rIns(OR, 0, 0, 24, 0), mk(0, 0, 1'b0, 0, CTL_WR, 24), msk(1, 1, 0, 1));
                issue(rIns(ADDU, 0, 1, 25, 0), mk(rf[1], 0, 1'b0, 0, CTL_WR, 25), mAlu);
                addRow(32'h0, 1'b1, 1'b0, 1'b0, 1'b1, 0, 32'hdead_beef);
                idleRow();
                idleRow();
        endtask

        initial begin
                CLK = 1'b0;
                nRST = 1'b0;
                instr = '0;
                npc = '0;
                ihit = 1'b0;
                stall = 1'b0;
                flush = 1'b0;
                wbEn = 1'b0;
                wbSel = '0;
                wbData = '0;
                expNow = '0;
                maskNow = '0;
                buildTable();
                repeat (RESET_CYCLES) @(posedge CLK);
                nRST <= 1'b1;
                for (row = 0; row < nRows; row++) begin
                        @(posedge CLK);
                        instr <= stim[row].instr;
                        npc <= stim[row].npc;
                        ihit <= stim[row].ihit;
                        stall <= stim[row].stall;
                        flush <= stim[row].flush;
                        wbEn <= stim[row].wbEn;
                        wbSel <= stim[row].wbSel;
                        wbData <= stim[row].wbData;
                        expNow <= expV[row];
                        maskNow <= maskV[row];
                end
                @(posedge CLK);
                maskNow <= '0;
                @(negedge CLK);
                $display("Rows: %0d, checks: %0d, errors: %0d", nRows, checks, errors);
                if (errors == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

        // Watchdog sized from the table length
        initial begin
                #1;
                #((nRows + RESET_CYCLES + 20) * 4);
                $display("Watchdog expired, the table did not finish in time");
                $display("Something failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: files.f
design/cpuTypesPkg.sv
design/ifidLatch.sv
design/controlDecoder.sv
design/registerFile.sv
design/idexLatch.sv
design/executeUnit.sv
design/cpuDecodeExecute.sv
sim/executeChecker.sv
sim/cpuDecodeExecuteTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpuDecodeExecuteTb -Mdir obj_dir
out=$(./obj_dir/VcpuDecodeExecuteTb)
echo "$out"
echo "$out" | grep -qx "Everything OK"
